//--- hw/mm_pkg.sv
// sizes, register map and shared types of the tiled matmul engine
package mm_pkg;

  localparam int NLanes       = 4;
  localparam int TileBeats    = 4;   // beats per inner tile (M)
  localparam int OupFifoDepth = 4;
  localparam int DataW        = 8;
  localparam int AccW         = 24;
  localparam int DimW         = 8;
  localparam int ShiftW       = 4;

  localparam int BeatW    = $clog2(TileBeats);
  localparam int CreditW  = $clog2(OupFifoDepth + 1);
  localparam int FifoPtrW = $clog2(OupFifoDepth);

  localparam int SatMax = 2 ** (DataW - 1) - 1;
  localparam int SatMin = -(2 ** (DataW - 1));

  // word addresses on the host bus
  localparam logic [1:0] RegCtrl    = 2'd0;   // bit 0 starts a job
  localparam logic [1:0] RegDims    = 2'd1;   // rows, cols, inner_tiles from bit 0 up
  localparam logic [1:0] RegRequant = 2'd2;   // shift in [3:0], bias_en in bit 4
  localparam logic [1:0] RegStatus  = 2'd3;   // busy in bit 0

  typedef enum logic [1:0] {
    Idle,
    MatMul,
    Drain
  } step_e;

  typedef logic [NLanes-1:0] lane_mask_t;

  typedef struct packed {
    logic [DimW-1:0]   rows;
    logic [DimW-1:0]   cols;
    logic [DimW-1:0]   inner_tiles;  // in units of TileBeats
    logic              bias_en;
    logic [ShiftW-1:0] shift;
    logic              start;        // single cycle
  } job_t;

  typedef logic signed [NLanes-1:0][DataW-1:0] vec_t;

  typedef logic [NLanes-1:0][AccW-1:0] acc_vec_t;

  typedef struct packed {
    logic       en;
    logic       first;      // load instead of add
    logic       last;       // closes an output row
    lane_mask_t lane_mask;
  } mac_cmd_t;

  typedef vec_t oup_row_t;

endpackage

//--- hw/mm_cfg_regs.sv
`timescale 1ns/1ps
// job registers behind a Wishbone classic slave
// control, dims and requant words plus a read-only busy status
module mm_cfg_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [1:0]           wb_adr_i,
  input  logic [31:0]          wb_dat_i,
  output logic [31:0]          wb_dat_o,
  output logic                 wb_ack_o,
  input  logic                 busy_i,
  output mm_pkg::job_t         job_o
);

  logic                      req;
  logic                      ack_q;
  logic                      start_q;
  logic [mm_pkg::DimW-1:0]   rows_q;
  logic [mm_pkg::DimW-1:0]   cols_q;
  logic [mm_pkg::DimW-1:0]   inner_q;
  logic [mm_pkg::ShiftW-1:0] shift_q;
  logic                      bias_en_q;
  logic [31:0]               rdata_q;

  assign req = wb_cyc_i & wb_stb_i & ~ack_q;  // new access only

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q     <= 1'b0;
      start_q   <= 1'b0;
      rows_q    <= '0;
      cols_q    <= '0;
      inner_q   <= '0;
      shift_q   <= '0;
      bias_en_q <= 1'b0;
    end else begin
      ack_q   <= req;
      start_q <= req & wb_we_i & (wb_adr_i == mm_pkg::RegCtrl) & wb_dat_i[0];
      if (req && wb_we_i) begin
        case (wb_adr_i)
          mm_pkg::RegDims: begin
            rows_q  <= wb_dat_i[mm_pkg::DimW-1:0];
            cols_q  <= wb_dat_i[2*mm_pkg::DimW-1:mm_pkg::DimW];
            inner_q <= wb_dat_i[3*mm_pkg::DimW-1:2*mm_pkg::DimW];
          end
          mm_pkg::RegRequant: begin
            shift_q   <= wb_dat_i[mm_pkg::ShiftW-1:0];
            bias_en_q <= wb_dat_i[mm_pkg::ShiftW];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      case (wb_adr_i)
        mm_pkg::RegDims:    rdata_q <= {{(32-3*mm_pkg::DimW){1'b0}}, inner_q, cols_q, rows_q};
        mm_pkg::RegRequant: rdata_q <= {{(31-mm_pkg::ShiftW){1'b0}}, bias_en_q, shift_q};
        mm_pkg::RegStatus:  rdata_q <= {31'b0, busy_i};
        default:            rdata_q <= '0;  // control reads as zero
      endcase
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = rdata_q;

  assign job_o = '{rows:        rows_q,
                   cols:        cols_q,
                   inner_tiles: inner_q,
                   bias_en:     bias_en_q,
                   shift:       shift_q,
                   start:       start_q};

endmodule

//--- hw/mm_ctrl.sv
`timescale 1ns/1ps
// step controller of the matmul engine
// walks inner tiles, column groups and rows, masks edge lanes, tracks output credits
module mm_ctrl (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  mm_pkg::job_t       job_i,
  input  logic               inp_valid_i,
  input  logic               wgt_valid_i,
  input  logic               bias_valid_i,
  output logic               inp_ready_o,
  output logic               wgt_ready_o,
  output logic               bias_ready_o,
  input  logic               oup_pop_i,
  output mm_pkg::mac_cmd_t   mac_cmd_o,
  output mm_pkg::lane_mask_t oup_mask_o,
  output logic               busy_o
);

  mm_pkg::step_e              step_d, step_q;
  logic [mm_pkg::BeatW-1:0]   beat_d, beat_q;
  logic [mm_pkg::DimW-1:0]    inner_tile_d, inner_tile_q;
  logic [mm_pkg::DimW-1:0]    tile_x_d, tile_x_q;
  logic [mm_pkg::DimW-1:0]    tile_y_d, tile_y_q;
  logic [mm_pkg::CreditW-1:0] credit_d, credit_q;
  mm_pkg::lane_mask_t         lane_mask;
  mm_pkg::lane_mask_t         oup_mask_q;
  logic [mm_pkg::DimW:0]      col_sum;
  logic [mm_pkg::DimW-1:0]    col_tiles;
  logic                       grant;
  logic                       accept;
  logic                       first_beat;
  logic                       last_beat;

  // column groups, rounded up
  assign col_sum   = {1'b0, job_i.cols} + (mm_pkg::DimW+1)'(mm_pkg::NLanes - 1);
  assign col_tiles = mm_pkg::DimW'(col_sum / mm_pkg::NLanes);

  always_comb begin
    for (int i = 0; i < mm_pkg::NLanes; i++) begin
      lane_mask[i] = (int'(tile_x_q) * mm_pkg::NLanes + i) < int'(job_i.cols);
    end
  end

  assign first_beat = (beat_q == '0) && (inner_tile_q == '0);
  assign last_beat  = (beat_q == mm_pkg::BeatW'(mm_pkg::TileBeats - 1)) &&
                      (inner_tile_q == job_i.inner_tiles - 1'b1);

  // no grant while every FIFO slot is spoken for
  assign grant  = (step_q == mm_pkg::MatMul) &&
                  (credit_q < mm_pkg::CreditW'(mm_pkg::OupFifoDepth));
  assign accept = grant & inp_valid_i & wgt_valid_i & bias_valid_i;

  assign inp_ready_o  = grant & wgt_valid_i & bias_valid_i;
  assign wgt_ready_o  = grant & inp_valid_i & bias_valid_i;
  assign bias_ready_o = grant & inp_valid_i & wgt_valid_i;

  assign mac_cmd_o = '{en: accept, first: first_beat, last: last_beat, lane_mask: lane_mask};

  always_comb begin
    step_d       = step_q;
    beat_d       = beat_q;
    inner_tile_d = inner_tile_q;
    tile_x_d     = tile_x_q;
    tile_y_d     = tile_y_q;
    case (step_q)
      mm_pkg::Idle: begin
        beat_d       = '0;
        inner_tile_d = '0;
        tile_x_d     = '0;
        tile_y_d     = '0;
        if (job_i.start) begin
          step_d = mm_pkg::MatMul;
        end
      end
      mm_pkg::MatMul: begin
        if (accept) begin
          beat_d = beat_q + 1'b1;
          if (beat_q == mm_pkg::BeatW'(mm_pkg::TileBeats - 1)) begin
            beat_d       = '0;
            inner_tile_d = inner_tile_q + 1'b1;
            if (last_beat) begin  // row of this column group done
              inner_tile_d = '0;
              tile_x_d     = tile_x_q + 1'b1;
              if (tile_x_q == col_tiles - 1'b1) begin
                tile_x_d = '0;
                tile_y_d = tile_y_q + 1'b1;
                if (tile_y_q == job_i.rows - 1'b1) begin
                  tile_y_d = '0;
                  step_d   = mm_pkg::Drain;
                end
              end
            end
          end
        end
      end
      mm_pkg::Drain: begin
        if (credit_q == '0) begin  // last row popped
          step_d = mm_pkg::Idle;
        end
      end
      default: step_d = mm_pkg::Idle;
    endcase
  end

  // rows handed to the datapath and not yet popped
  always_comb begin
    credit_d = credit_q;
    if (accept && last_beat && !oup_pop_i) begin
      credit_d = credit_q + 1'b1;
    end else if (!(accept && last_beat) && oup_pop_i) begin
      credit_d = credit_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q       <= mm_pkg::Idle;
      beat_q       <= '0;
      inner_tile_q <= '0;
      tile_x_q     <= '0;
      tile_y_q     <= '0;
      credit_q     <= '0;
      oup_mask_q   <= '0;
    end else begin
      step_q       <= step_d;
      beat_q       <= beat_d;
      inner_tile_q <= inner_tile_d;
      tile_x_q     <= tile_x_d;
      tile_y_q     <= tile_y_d;
      credit_q     <= credit_d;
      if (accept && last_beat) begin
        oup_mask_q <= lane_mask;  // held until the row is requantized
      end
    end
  end

  assign oup_mask_o = oup_mask_q;
  assign busy_o     = (step_q != mm_pkg::Idle) | job_i.start;

endmodule

//--- hw/mm_mac_array.sv
`timescale 1ns/1ps
// N lanes of signed multiply-accumulate with a broadcast activation
module mm_mac_array (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  mm_pkg::mac_cmd_t           cmd_i,
  input  logic signed [mm_pkg::DataW-1:0] act_i,
  input  mm_pkg::vec_t               wgt_i,
  output mm_pkg::acc_vec_t           acc_o,
  output logic                       row_done_o
);

  logic row_done_q;

  for (genvar i = 0; i < mm_pkg::NLanes; i++) begin : g_lane
    logic signed [2*mm_pkg::DataW-1:0] prod;
    logic [mm_pkg::AccW-1:0]           acc_q;

    assign prod = act_i * $signed(wgt_i[i]);

    always_ff @(posedge clk_i) begin
      if (cmd_i.en) begin
        if (!cmd_i.lane_mask[i]) begin
          acc_q <= '0;  // lane past cols
        end else if (cmd_i.first) begin
          acc_q <= mm_pkg::AccW'(prod);
        end else begin
          acc_q <= acc_q + mm_pkg::AccW'(prod);
        end
      end
    end

    assign acc_o[i] = acc_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_done_q <= 1'b0;
    end else begin
      row_done_q <= cmd_i.en & cmd_i.last;
    end
  end

  assign row_done_o = row_done_q;

endmodule

//--- hw/mm_requant.sv
`timescale 1ns/1ps
// bias add, arithmetic shift and 8-bit saturation of a finished row
// registered stage, pushes one cycle after row_done
module mm_requant (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  mm_pkg::acc_vec_t            acc_i,
  input  logic                        row_done_i,
  input  mm_pkg::vec_t                bias_i,
  input  logic                        bias_en_i,
  input  logic [mm_pkg::ShiftW-1:0]   shift_i,
  input  mm_pkg::lane_mask_t          mask_i,
  output logic                        push_o,
  output mm_pkg::oup_row_t            row_o
);

  mm_pkg::vec_t     bias_q;
  mm_pkg::oup_row_t row_d;
  mm_pkg::oup_row_t row_q;
  logic             push_q;

  // on row_done this holds the bias of the row's last beat
  always_ff @(posedge clk_i) begin
    bias_q <= bias_i;
  end

  for (genvar i = 0; i < mm_pkg::NLanes; i++) begin : g_lane
    logic signed [mm_pkg::AccW:0] bias_ext;
    logic signed [mm_pkg::AccW:0] sum;
    logic signed [mm_pkg::AccW:0] shifted;
    logic [mm_pkg::DataW-1:0]     sat;

    assign bias_ext = (bias_en_i && mask_i[i]) ? (mm_pkg::AccW+1)'($signed(bias_q[i])) : '0;
    assign sum      = $signed({acc_i[i][mm_pkg::AccW-1], acc_i[i]}) + bias_ext;
    assign shifted  = sum >>> shift_i;

    always_comb begin
      if (shifted > mm_pkg::SatMax) begin
        sat = mm_pkg::DataW'(mm_pkg::SatMax);
      end else if (shifted < mm_pkg::SatMin) begin
        sat = mm_pkg::DataW'(mm_pkg::SatMin);
      end else begin
        sat = shifted[mm_pkg::DataW-1:0];
      end
    end

    assign row_d[i] = mask_i[i] ? sat : '0;
  end

  always_ff @(posedge clk_i) begin
    if (row_done_i) begin
      row_q <= row_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q <= 1'b0;
    end else begin
      push_q <= row_done_i;
    end
  end

  assign push_o = push_q;
  assign row_o  = row_q;

endmodule

//--- hw/mm_oup_fifo.sv
`timescale 1ns/1ps
// output row FIFO, valid/ready on the read side
module mm_oup_fifo (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  mm_pkg::oup_row_t row_i,
  output logic             valid_o,
  input  logic             ready_i,
  output mm_pkg::oup_row_t row_o,
  output logic             pop_o
);

  mm_pkg::oup_row_t            mem [mm_pkg::OupFifoDepth];
  logic [mm_pkg::FifoPtrW:0]   wr_ptr_q;
  logic [mm_pkg::FifoPtrW:0]   rd_ptr_q;

  // extra pointer bit tells full from empty
  assign valid_o = wr_ptr_q != rd_ptr_q;
  assign pop_o   = valid_o & ready_i;
  assign row_o   = mem[rd_ptr_q[mm_pkg::FifoPtrW-1:0]];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q[mm_pkg::FifoPtrW-1:0]] <= row_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // credits keep this from overflowing
      end
      if (pop_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

endmodule

//--- hw/mm_top.sv
`timescale 1ns/1ps
// tiled matmul engine top
// register block, step controller, MAC array, requant stage and output FIFO
module mm_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [1:0]                      wb_adr_i,
  input  logic [31:0]                     wb_dat_i,
  output logic [31:0]                     wb_dat_o,
  output logic                            wb_ack_o,
  input  logic                            inp_valid_i,
  output logic                            inp_ready_o,
  input  logic signed [mm_pkg::DataW-1:0] act_i,
  input  logic                            wgt_valid_i,
  output logic                            wgt_ready_o,
  input  mm_pkg::vec_t                    wgt_i,
  input  logic                            bias_valid_i,
  output logic                            bias_ready_o,
  input  mm_pkg::vec_t                    bias_i,
  output logic                            oup_valid_o,
  input  logic                            oup_ready_i,
  output mm_pkg::oup_row_t                oup_data_o,
  output logic                            busy_o
);

  mm_pkg::job_t       job;
  mm_pkg::mac_cmd_t   mac_cmd;
  mm_pkg::lane_mask_t oup_mask;
  mm_pkg::acc_vec_t   acc;
  mm_pkg::oup_row_t   rq_row;
  logic               row_done;
  logic               rq_push;
  logic               oup_pop;

  mm_cfg_regs i_cfg_regs (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .busy_i (busy_o),
    .job_o  (job)
  );

  mm_ctrl i_ctrl (
    .clk_i, .rst_ni,
    .job_i        (job),
    .inp_valid_i, .wgt_valid_i, .bias_valid_i,
    .inp_ready_o, .wgt_ready_o, .bias_ready_o,
    .oup_pop_i    (oup_pop),
    .mac_cmd_o    (mac_cmd),
    .oup_mask_o   (oup_mask),
    .busy_o
  );

  mm_mac_array i_mac_array (
    .clk_i, .rst_ni,
    .cmd_i      (mac_cmd),
    .act_i,
    .wgt_i,
    .acc_o      (acc),
    .row_done_o (row_done)
  );

  mm_requant i_requant (
    .clk_i, .rst_ni,
    .acc_i      (acc),
    .row_done_i (row_done),
    .bias_i,
    .bias_en_i  (job.bias_en),
    .shift_i    (job.shift),
    .mask_i     (oup_mask),
    .push_o     (rq_push),
    .row_o      (rq_row)
  );

  mm_oup_fifo i_oup_fifo (
    .clk_i, .rst_ni,
    .push_i  (rq_push),
    .row_i   (rq_row),
    .valid_o (oup_valid_o),
    .ready_i (oup_ready_i),
    .row_o   (oup_data_o),
    .pop_o   (oup_pop)
  );

endmodule

//--- include/tb_mm_ref.svh
// reference model and job helpers for the matmul engine testbench
// included inside the testbench module
`ifndef TB_MM_REF_SVH
`define TB_MM_REF_SVH

typedef int mat_t[][];

// extreme draws pick only the two range ends
function automatic mat_t rand_mat(int n_rows, int n_cols, bit extreme);
  mat_t m;
  m = new[n_rows];
  for (int r = 0; r < n_rows; r++) begin
    m[r] = new[n_cols];
    for (int c = 0; c < n_cols; c++) begin
      if (extreme) begin
        m[r][c] = ($urandom_range(1) != 0) ? mm_pkg::SatMax : mm_pkg::SatMin;
      end else begin
        m[r][c] = int'($urandom_range(255)) + mm_pkg::SatMin;
      end
    end
  end
  return m;
endfunction

// lanes of column group x, zero past the end of the row
function automatic mm_pkg::vec_t lane_vec(int row[], int x);
  mm_pkg::vec_t v;
  int col;
  v = '0;
  for (int l = 0; l < mm_pkg::NLanes; l++) begin
    col = x * mm_pkg::NLanes + l;
    if (col < row.size()) begin
      v[l] = mm_pkg::DataW'(row[col]);
    end
  end
  return v;
endfunction

function automatic mm_pkg::oup_row_t ref_row(mat_t a, mat_t b, int bias[], int y, int x,
                                             bit bias_en, int shift);
  mm_pkg::oup_row_t row;
  int col;
  int acc;
  row = '0;
  for (int l = 0; l < mm_pkg::NLanes; l++) begin
    col = x * mm_pkg::NLanes + l;
    if (col < b[0].size()) begin
      acc = 0;
      for (int k = 0; k < a[y].size(); k++) begin
        acc += a[y][k] * b[k][col];
      end
      acc = (acc <<< (32 - mm_pkg::AccW)) >>> (32 - mm_pkg::AccW);  // accumulator wraps
      if (bias_en) begin
        acc += bias[col];
      end
      acc = acc >>> shift;
      if (acc > mm_pkg::SatMax) begin
        acc = mm_pkg::SatMax;
      end else if (acc < mm_pkg::SatMin) begin
        acc = mm_pkg::SatMin;
      end
      row[l] = mm_pkg::DataW'(acc);
    end
  end
  return row;
endfunction

function automatic logic [31:0] dims_word(int rows, int cols, int inner_tiles);
  return {8'b0, 8'(inner_tiles), 8'(cols), 8'(rows)};
endfunction

function automatic logic [31:0] requant_word(int shift, bit bias_en);
  return {27'b0, bias_en, 4'(shift)};
endfunction

`endif

//--- test/tb_mm_top.sv
`timescale 1ns/1ps
// testbench of the tiled matmul engine
// random jobs over Wishbone and three input streams, rows checked against a reference model
module tb_mm_top;

  `include "tb_mm_ref.svh"

  localparam int NJobs = 5;

  logic                            clk;
  logic                            rst_n;
  logic                            wb_cyc;
  logic                            wb_stb;
  logic                            wb_we;
  logic [1:0]                      wb_adr;
  logic [31:0]                     wb_dat_w;
  logic [31:0]                     wb_dat_r;
  logic                            wb_ack;
  logic                            inp_valid;
  logic                            inp_ready;
  logic signed [mm_pkg::DataW-1:0] act;
  logic                            wgt_valid;
  logic                            wgt_ready;
  mm_pkg::vec_t                    wgt;
  logic                            bias_valid;
  logic                            bias_ready;
  mm_pkg::vec_t                    bias;
  logic                            oup_valid;
  logic                            oup_ready;
  mm_pkg::oup_row_t                oup_data;
  logic                            busy;

  // one entry per job
  int job_rows[NJobs]    = '{3, 2, 2, 4, 2};
  int job_cols[NJobs]    = '{8, 6, 5, 8, 3};
  int job_inner[NJobs]   = '{2, 1, 2, 1, 1};
  bit job_bias[NJobs]    = '{0, 0, 1, 1, 1};
  int job_shift[NJobs]   = '{4, 3, 8, 5, 2};
  bit job_extreme[NJobs] = '{0, 0, 1, 0, 0};
  bit job_bp[NJobs]      = '{0, 0, 0, 1, 0};
  bit job_restart[NJobs] = '{0, 0, 0, 0, 1};  // second start while busy

  mm_pkg::oup_row_t exp_q[$];
  mm_pkg::oup_row_t exp_row;
  int               value_errs;
  int               other_errs;
  int               rows_sent;
  int               rows_popped;
  int               cycles;
  int               cycle_limit;
  bit               bp_en;

  mm_top dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_dat_w),
    .wb_dat_o     (wb_dat_r),
    .wb_ack_o     (wb_ack),
    .inp_valid_i  (inp_valid),
    .inp_ready_o  (inp_ready),
    .act_i        (act),
    .wgt_valid_i  (wgt_valid),
    .wgt_ready_o  (wgt_ready),
    .wgt_i        (wgt),
    .bias_valid_i (bias_valid),
    .bias_ready_o (bias_ready),
    .bias_i       (bias),
    .oup_valid_o  (oup_valid),
    .oup_ready_i  (oup_ready),
    .oup_data_o   (oup_data),
    .busy_o       (busy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic check_row(input mm_pkg::oup_row_t exp, input mm_pkg::oup_row_t got);
    if (got !== exp) begin
      value_errs++;
      $display("Fail at %0t: output row expected %h received %h", $time, exp, got);
    end
  endtask

  task automatic check_word(input logic [31:0] exp, input logic [31:0] got, input string what);
    if (got !== exp) begin
      value_errs++;
      $display("Fail at %0t: %s expected %h received %h", $time, what, exp, got);
    end
  endtask

  // request starts just after a rising edge, ack is due in the next cycle
  task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waits;
    waits    = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack) begin
      waits++;
      @(negedge clk);
    end
    rdata = wb_dat_r;
    if (waits != 1) begin
      other_errs++;
      $display("bus ack at %0t came %0d cycles after the request instead of 1", $time, waits);
    end
    @(posedge clk);
    #1;
    if (wb_ack) begin
      other_errs++;
      $display("bus ack at %0t held for more than one cycle", $time);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // holds the beat until all three streams transfer
  task automatic send_beat(input logic signed [mm_pkg::DataW-1:0] a, input mm_pkg::vec_t w,
                           input mm_pkg::vec_t b);
    bit taken;
    taken      = 1'b0;
    inp_valid  = 1'b1;
    wgt_valid  = 1'b1;
    bias_valid = 1'b1;
    act        = a;
    wgt        = w;
    bias       = b;
    while (!taken) begin
      @(negedge clk);
      taken = inp_ready && wgt_ready && bias_ready;
      @(posedge clk);
      #1;
    end
    inp_valid  = 1'b0;
    wgt_valid  = 1'b0;
    bias_valid = 1'b0;
  endtask

  function automatic int beats_of_job(int j);
    return job_rows[j] * ((job_cols[j] + mm_pkg::NLanes - 1) / mm_pkg::NLanes) *
           job_inner[j] * mm_pkg::TileBeats;
  endfunction

  task automatic run_job(input int j);
    mat_t        a;
    mat_t        b;
    mat_t        bm;
    int          bias_v[];
    int          k_len;
    int          col_tiles;
    logic [31:0] rdata;
    k_len     = job_inner[j] * mm_pkg::TileBeats;
    col_tiles = (job_cols[j] + mm_pkg::NLanes - 1) / mm_pkg::NLanes;
    a         = rand_mat(job_rows[j], k_len, job_extreme[j]);
    b         = rand_mat(k_len, job_cols[j], job_extreme[j]);
    bm        = rand_mat(1, job_cols[j], job_extreme[j]);
    bias_v    = bm[0];
    bp_en     = job_bp[j];
    bus_access(1'b1, mm_pkg::RegDims, dims_word(job_rows[j], job_cols[j], job_inner[j]), rdata);
    bus_access(1'b1, mm_pkg::RegRequant, requant_word(job_shift[j], job_bias[j]), rdata);
    bus_access(1'b0, mm_pkg::RegDims, 32'h0, rdata);
    check_word(dims_word(job_rows[j], job_cols[j], job_inner[j]), rdata, "dims readback");
    bus_access(1'b0, mm_pkg::RegRequant, 32'h0, rdata);
    check_word(requant_word(job_shift[j], job_bias[j]), rdata, "requant readback");
    for (int y = 0; y < job_rows[j]; y++) begin
      for (int x = 0; x < col_tiles; x++) begin
        exp_q.push_back(ref_row(a, b, bias_v, y, x, job_bias[j], job_shift[j]));
      end
    end
    bus_access(1'b1, mm_pkg::RegCtrl, 32'h1, rdata);
    bus_access(1'b0, mm_pkg::RegStatus, 32'h0, rdata);
    check_word(32'h1, rdata, "status during job");
    if (job_restart[j]) begin
      bus_access(1'b1, mm_pkg::RegCtrl, 32'h1, rdata);  // must be dropped
    end
    for (int y = 0; y < job_rows[j]; y++) begin
      for (int x = 0; x < col_tiles; x++) begin
        for (int k = 0; k < k_len; k++) begin
          send_beat(mm_pkg::DataW'(a[y][k]), lane_vec(b[k], x), lane_vec(bias_v, x));
          if (k == k_len - 1) begin
            rows_sent++;
          end
        end
      end
    end
    while (busy) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    if (exp_q.size() != 0) begin
      other_errs++;
      $display("job %0d ended with %0d expected rows never delivered", j, exp_q.size());
      exp_q.delete();
    end
    bus_access(1'b0, mm_pkg::RegStatus, 32'h0, rdata);
    check_word(32'h0, rdata, "status after job");
    if (job_restart[j]) begin
      repeat (20) @(posedge clk);
      #1;
      if (busy) begin
        other_errs++;
        $display("a start written while busy launched another job");
      end
    end
    bp_en = 1'b0;
  endtask

  // output handshakes and the credit limit on the input readies
  always @(negedge clk) begin
    if (rst_n) begin
      if ((rows_sent - rows_popped >= mm_pkg::OupFifoDepth) &&
          (inp_ready || wgt_ready || bias_ready)) begin
        other_errs++;
        $display("input ready high at %0t with %0d rows in flight", $time,
                 rows_sent - rows_popped);
      end
      if (oup_valid && oup_ready) begin
        rows_popped++;
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("output row %h at %0t arrived with no row expected", oup_data, $time);
        end else begin
          exp_row = exp_q.pop_front();
          check_row(exp_row, oup_data);
        end
      end
    end
  end

  initial begin
    oup_ready = 1'b0;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      #1;
      oup_ready = bp_en ? ($urandom_range(3) == 0) : 1'b1;
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= cycle_limit) begin
        $display("run timed out after %0d cycles", cycles);
        $display("Finished with errors");
        $finish;
      end
    end
  end

  initial begin
    void'($urandom(32'h2f1a));
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    inp_valid   = 1'b0;
    act         = '0;
    wgt_valid   = 1'b0;
    wgt         = '0;
    bias_valid  = 1'b0;
    bias        = '0;
    bp_en       = 1'b0;
    value_errs  = 0;
    other_errs  = 0;
    rows_sent   = 0;
    rows_popped = 0;
    cycle_limit = 2000;
    for (int j = 0; j < NJobs; j++) begin
      cycle_limit += 64 * beats_of_job(j);
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int j = 0; j < NJobs; j++) begin
      run_job(j);
    end
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+include
hw/mm_pkg.sv
hw/mm_cfg_regs.sv
hw/mm_ctrl.sv
hw/mm_mac_array.sv
hw/mm_requant.sv
hw/mm_oup_fifo.sv
hw/mm_top.sv
test/tb_mm_top.sv
